// ==== build.f ====
+incdir+include
verilog/mmu_rx_reg_pkg.sv
verilog/reg_bus_if.sv
verilog/mmu_rx_cpu_port.sv
verilog/mmu_rx_cfg_bank.sv
verilog/mmu_rx_err_bank.sv
verilog/mmu_rx_cnt_bank.sv
verilog/mmu_rx_reg_top.sv
verif/tb_mmu_rx_reg.sv

// ==== Bender.yml ====
package:
  name: mmu_rx_reg

sources:
  # design, in compile order
  - files:
      - verilog/mmu_rx_reg_pkg.sv
      - verilog/reg_bus_if.sv
      - verilog/mmu_rx_cpu_port.sv
      - verilog/mmu_rx_cfg_bank.sv
      - verilog/mmu_rx_err_bank.sv
      - verilog/mmu_rx_cnt_bank.sv
      - verilog/mmu_rx_reg_top.sv

  # directed testbench, top module tb_mmu_rx_reg
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_mmu_rx_reg.sv

// ==== include/tb_mmu_rx_tasks.svh ====
// CPU bus access and compare tasks that the register block testbench includes in its module
`ifndef TB_MMU_RX_TASKS_SVH
`define TB_MMU_RX_TASKS_SVH

// ----------------------------------------------------------------------
// bus access
// ----------------------------------------------------------------------
function automatic reg_addr_t make_addr(input logic [ID_W-1:0] id, input logic [2:0] zero,
                                        input reg_bank_e bank, input int offs);
    return {id, zero, bank, reg_offs_t'(offs)};
endfunction

task automatic wait_clocks(input int n);
    for (int i = 0; i < n; i++) begin
        @(posedge clk_sys);
    end
endtask

// the strobe is sampled on the second edge and outputs settle by the following negedge
task automatic bus_write(input reg_addr_t addr, input reg_word_t data);
    @(posedge clk_sys);
    cpu_addr    <= addr;
    cpu_data_in <= data;
    cpu_wr      <= 1'b1;
    @(posedge clk_sys);
    cpu_wr <= 1'b0;
    @(negedge clk_sys);
endtask

// address held through both read stages
task automatic bus_read(input reg_addr_t addr, output reg_word_t data);
    @(posedge clk_sys);
    cpu_addr <= addr;
    cpu_wr   <= 1'b0;
    wait_clocks(2);
    @(negedge clk_sys);
    data = cpu_data_out;
endtask

// ----------------------------------------------------------------------
// compare
// ----------------------------------------------------------------------
task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
endtask

task automatic check_cfg(input string name, input logic [TMOUT_W-1:0] got,
                         input logic [TMOUT_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %s: got 0x%04h, expected 0x%04h", name, got, exp);
    end
endtask

task automatic read_check(input reg_addr_t addr, input reg_word_t exp);
    reg_word_t data;
    bus_read(addr, data);
    check_word($sformatf("cpu_data_out@%06h", addr), data, exp);
endtask

`endif

// ==== verif/tb_mmu_rx_reg.sv ====
// directed testbench that runs as the simulation top of the receive MMU register block
`timescale 1ns/100ps
`default_nettype none

module tb_mmu_rx_reg
    import mmu_rx_reg_pkg::*;
();

    localparam logic [ID_W-1:0] OWN_ID = 12'h001;

    logic               clk_sys;
    logic               rst;
    reg_addr_t          cpu_addr;
    reg_word_t          cpu_data_in;
    logic               cpu_wr;
    logic               cnt_reg_clr;
    reg_word_t          cpu_data_out;
    reg_word_t          sts_in [NUM_STS];
    reg_word_t          rxbd_err;
    reg_word_t          rxpkt_err;
    logic [TMOUT_W-1:0] axi_tmout_err;
    logic [NUM_CNT-1:0] ev;
    reg_word_t          mmu_rx_cfg;
    logic [TIMER_W-1:0] timer_1us_cfg;
    logic [TMOUT_W-1:0] tmout_us_cfg;

    logic [31:0]        lfsr_state;
    int                 error_count;
    int                 check_count;
    bit                 reset_ok;
    // expected register contents
    logic [TIMER_W-1:0] exp_timer;
    logic [TMOUT_W-1:0] exp_tmout;
    reg_word_t          exp_rxcfg;
    reg_word_t          exp_err [NUM_ERR];

    mmu_rx_reg_top #(
        .BLOCK_ID (OWN_ID)
    ) dut (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .cpu_addr        (cpu_addr),
        .cpu_data_in     (cpu_data_in),
        .cpu_wr          (cpu_wr),
        .cnt_reg_clr     (cnt_reg_clr),
        .cpu_data_out    (cpu_data_out),
        .rxbd_sta        (sts_in[0]),
        .rxpkt_sta       (sts_in[1]),
        .rxpkt_sta1      (sts_in[2]),
        .eoc_tag_ff_stat (sts_in[3]),
        .rxbd_err        (rxbd_err),
        .rxpkt_err       (rxpkt_err),
        .axi_tmout_err   (axi_tmout_err),
        .rxpkt_en        ({ev[EV_RXPKT3], ev[EV_RXPKT2], ev[EV_RXPKT1], ev[EV_RXPKT0]}),
        .txpkt_en        (ev[EV_TXPKT]),
        .rxbd_en         (ev[EV_RXBD]),
        .rdcmd_en        (ev[EV_RDCMD]),
        .mmu_rx_cfg      (mmu_rx_cfg),
        .timer_1us_cfg   (timer_1us_cfg),
        .tmout_us_cfg    (tmout_us_cfg)
    );

    always #50 clk_sys = ~clk_sys;

    `include "tb_mmu_rx_tasks.svh"

    // ----------------------------------------------------------------------
    // random data
    // ----------------------------------------------------------------------
    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic reg_word_t random_bits(input int nbits);
        reg_word_t w;
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[DATA_W-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic wait_reset_done(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < 10) begin
            @(negedge clk_sys);
            ok = !rst && !$isunknown({cpu_data_out, mmu_rx_cfg, timer_1us_cfg, tmout_us_cfg});
            cycles++;
        end
    endtask

    task automatic check_cfg_outputs();
        check_cfg("timer_1us_cfg", timer_1us_cfg, exp_timer);
        check_cfg("tmout_us_cfg", tmout_us_cfg, exp_tmout);
        check_word("mmu_rx_cfg", mmu_rx_cfg, exp_rxcfg);
        read_check(make_addr(OWN_ID, 3'b000, BANK_CFG, 0), 32'(exp_timer));
        read_check(make_addr(OWN_ID, 3'b000, BANK_CFG, 1), 32'(exp_tmout));
        read_check(make_addr(OWN_ID, 3'b000, BANK_CFG, 2), exp_rxcfg);
    endtask

    task automatic read_reset_values();
        exp_timer = 8'd200;
        exp_tmout = 16'hFFFF;
        exp_rxcfg = 32'h8000_0012;
        check_cfg_outputs();
        for (int i = 0; i < NUM_ERR; i++) begin
            read_check(make_addr(OWN_ID, 3'b000, BANK_ERR, i), '0);
        end
        for (int i = 0; i < NUM_CNT; i++) begin
            read_check(make_addr(OWN_ID, 3'b000, BANK_CNT, i), '0);
        end
    endtask

    task automatic write_cfg_regs();
        reg_word_t w;
        w = random_bits(32);
        bus_write(make_addr(OWN_ID, 3'b000, BANK_CFG, 0), w);
        exp_timer = w[7:0];
        w = random_bits(32);
        bus_write(make_addr(OWN_ID, 3'b000, BANK_CFG, 1), w);
        exp_tmout = w[15:0];
        w = random_bits(32);
        bus_write(make_addr(OWN_ID, 3'b000, BANK_CFG, 2), w);
        exp_rxcfg = w;
        check_cfg_outputs();
    endtask

    task automatic set_clear_errors();
        reg_word_t flags [NUM_ERR];
        reg_word_t mask;
        flags[0] = random_bits(32);
        flags[1] = random_bits(32);
        flags[2] = random_bits(16);
        @(posedge clk_sys);
        rxbd_err      <= flags[0];
        rxpkt_err     <= flags[1];
        axi_tmout_err <= flags[2][TMOUT_W-1:0];
        @(posedge clk_sys);
        rxbd_err      <= '0;
        rxpkt_err     <= '0;
        axi_tmout_err <= '0;
        for (int i = 0; i < NUM_ERR; i++) begin
            exp_err[i] = flags[i];
            read_check(make_addr(OWN_ID, 3'b000, BANK_ERR, i), exp_err[i]);
        end
        // writing ones clears those bits while the other registers keep theirs
        for (int i = 0; i < NUM_ERR; i++) begin
            mask = random_bits(32);
            bus_write(make_addr(OWN_ID, 3'b000, BANK_ERR, i), mask);
            exp_err[i] = exp_err[i] & ~mask;
            for (int j = 0; j < NUM_ERR; j++) begin
                read_check(make_addr(OWN_ID, 3'b000, BANK_ERR, j), exp_err[j]);
            end
        end
    endtask

    task automatic read_status_words();
        reg_word_t vals [NUM_STS];
        for (int i = 0; i < NUM_STS; i++) begin
            vals[i] = random_bits(32);
        end
        @(posedge clk_sys);
        sts_in[0] <= vals[0];
        sts_in[1] <= vals[1];
        sts_in[2] <= vals[2];
        sts_in[3] <= vals[3];
        for (int i = 0; i < NUM_STS; i++) begin
            read_check(make_addr(OWN_ID, 3'b000, BANK_STS, i), vals[i]);
        end
        read_check(make_addr(OWN_ID, 3'b000, BANK_STS, 4), '0);
    endtask

    task automatic count_events();
        int                 counts [NUM_CNT];
        logic [NUM_CNT-1:0] pat;
        // distinct lane counts show that the lanes are independent
        counts = '{3, 5, 2, 7, 4, 6, 1};
        for (int c = 0; c < 7; c++) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                pat[i] = (c < counts[i]);
            end
            @(posedge clk_sys);
            ev <= pat;
        end
        @(posedge clk_sys);
        ev <= '0;
        for (int i = 0; i < NUM_CNT; i++) begin
            read_check(make_addr(OWN_ID, 3'b000, BANK_CNT, i), reg_word_t'(counts[i]));
        end
        read_check(make_addr(OWN_ID, 3'b000, BANK_CNT, 7), '0);
        @(posedge clk_sys);
        cnt_reg_clr <= 1'b1;
        @(posedge clk_sys);
        cnt_reg_clr <= 1'b0;
        for (int i = 0; i < NUM_CNT; i++) begin
            read_check(make_addr(OWN_ID, 3'b000, BANK_CNT, i), '0);
        end
    endtask

    task automatic decode_addresses();
        reg_word_t w;
        w = random_bits(32);
        bus_write(make_addr(12'h002, 3'b000, BANK_CFG, 0), w);
        bus_write(make_addr(OWN_ID, 3'b100, BANK_CFG, 1), w);
        bus_write(make_addr(12'h801, 3'b000, BANK_ERR, 0), '1);
        check_cfg_outputs();
        read_check(make_addr(OWN_ID, 3'b000, BANK_ERR, 0), exp_err[0]);
        // misses read as zero
        read_check(make_addr(12'h002, 3'b000, BANK_CFG, 2), '0);
        read_check(make_addr(OWN_ID, 3'b010, BANK_CFG, 2), '0);
        bus_write(make_addr(OWN_ID, 3'b000, BANK_CNT, 0), w);
        read_check(make_addr(OWN_ID, 3'b000, BANK_CNT, 0), '0);
        bus_write(make_addr(OWN_ID, 3'b000, BANK_STS, 0), w);
        read_check(make_addr(OWN_ID, 3'b000, BANK_STS, 0), sts_in[0]);
        check_cfg_outputs();
        read_check(make_addr(OWN_ID, 3'b000, BANK_ERR, 0), exp_err[0]);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        clk_sys       = 1'b0;
        rst           = 1'b1;
        cpu_addr      = '0;
        cpu_data_in   = '0;
        cpu_wr        = 1'b0;
        cnt_reg_clr   = 1'b0;
        sts_in        = '{default: '0};
        rxbd_err      = '0;
        rxpkt_err     = '0;
        axi_tmout_err = '0;
        ev            = '0;
        lfsr_state    = 32'd36;
        error_count   = 0;
        check_count   = 0;
        wait_clocks(2);
        rst <= 1'b0;
        wait_reset_done(reset_ok);
        if (!reset_ok) begin
            error_count++;
            $display("timeout: DUT outputs not settled within 10 cycles after reset");
        end else begin
            read_reset_values();
            write_cfg_regs();
            set_clear_errors();
            read_status_words();
            count_events();
            decode_addresses();
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/mmu_rx_reg_top.sv ====
// top level of the receive MMU register block, connecting the CPU port to the four banks
`timescale 1ns/100ps
`default_nettype none

module mmu_rx_reg_top
    import mmu_rx_reg_pkg::*;
#(
    parameter logic [ID_W-1:0] BLOCK_ID = 12'h001
) (
    input  wire                     clk_sys,
    input  wire                     rst,
    // CPU access
    input  wire reg_addr_t          cpu_addr,
    input  wire reg_word_t          cpu_data_in,
    input  wire                     cpu_wr,
    input  wire                     cnt_reg_clr,
    output reg_word_t               cpu_data_out,
    // status words
    input  wire reg_word_t          rxbd_sta,
    input  wire reg_word_t          rxpkt_sta,
    input  wire reg_word_t          rxpkt_sta1,
    input  wire reg_word_t          eoc_tag_ff_stat,
    // error flags
    input  wire reg_word_t          rxbd_err,
    input  wire reg_word_t          rxpkt_err,
    input  wire logic [TMOUT_W-1:0] axi_tmout_err,
    // counter events
    input  wire logic [3:0]         rxpkt_en,
    input  wire                     txpkt_en,
    input  wire                     rxbd_en,
    input  wire                     rdcmd_en,
    // config outputs
    output reg_word_t               mmu_rx_cfg,
    output logic [TIMER_W-1:0]      timer_1us_cfg,
    output logic [TMOUT_W-1:0]      tmout_us_cfg
);

    reg_word_t          cfg_rdata;
    reg_word_t          err_rdata;
    reg_word_t          cnt_rdata;
    reg_word_t          sts_words [NUM_STS];
    logic [NUM_CNT-1:0] cnt_events;

    reg_bus_if bus ();

    assign sts_words[0] = rxbd_sta;
    assign sts_words[1] = rxpkt_sta;
    assign sts_words[2] = rxpkt_sta1;
    assign sts_words[3] = eoc_tag_ff_stat;

    // event bits in counter offset order
    assign cnt_events[EV_RXBD]   = rxbd_en;
    assign cnt_events[EV_RDCMD]  = rdcmd_en;
    assign cnt_events[EV_RXPKT0] = rxpkt_en[0];
    assign cnt_events[EV_RXPKT1] = rxpkt_en[1];
    assign cnt_events[EV_RXPKT2] = rxpkt_en[2];
    assign cnt_events[EV_RXPKT3] = rxpkt_en[3];
    assign cnt_events[EV_TXPKT]  = txpkt_en;

    mmu_rx_cpu_port #(
        .BLOCK_ID (BLOCK_ID)
    ) u_cpu_port (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .cpu_addr     (cpu_addr),
        .cpu_data_in  (cpu_data_in),
        .cpu_wr       (cpu_wr),
        .bus          (bus.master),
        .cfg_rdata    (cfg_rdata),
        .err_rdata    (err_rdata),
        .cnt_rdata    (cnt_rdata),
        .sts_words    (sts_words),
        .cpu_data_out (cpu_data_out)
    );

    mmu_rx_cfg_bank u_cfg_bank (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .bus           (bus.slave),
        .rdata         (cfg_rdata),
        .timer_1us_cfg (timer_1us_cfg),
        .tmout_us_cfg  (tmout_us_cfg),
        .mmu_rx_cfg    (mmu_rx_cfg)
    );

    mmu_rx_err_bank u_err_bank (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .bus           (bus.slave),
        .rxbd_err      (rxbd_err),
        .rxpkt_err     (rxpkt_err),
        .axi_tmout_err (axi_tmout_err),
        .rdata         (err_rdata)
    );

    mmu_rx_cnt_bank u_cnt_bank (
        .clk_sys (clk_sys),
        .rst     (rst),
        .bus     (bus.slave),
        .cnt_clr (cnt_reg_clr),
        .events  (cnt_events),
        .rdata   (cnt_rdata)
    );

endmodule

`default_nettype wire

// ==== verilog/mmu_rx_cnt_bank.sv ====
// wrapping 32-bit event counters of the receive MMU with one shared clear
`timescale 1ns/100ps
`default_nettype none

module mmu_rx_cnt_bank
    import mmu_rx_reg_pkg::*;
(
    input  wire                     clk_sys,
    input  wire                     rst,
    reg_bus_if.slave                bus,
    input  wire                     cnt_clr,
    input  wire logic [NUM_CNT-1:0] events,
    output reg_word_t               rdata
);

    localparam int CNT_IDX_W = $clog2(NUM_CNT);

    reg_word_t cnt_q [NUM_CNT];

    // ----------------------------------------------------------------------
    // counters
    // ----------------------------------------------------------------------
    // one counter per event bit where a clear beats an increment
    for (genvar i = 0; i < NUM_CNT; i++) begin : g_cnt
        always_ff @(posedge clk_sys or posedge rst) begin
            if (rst) begin
                cnt_q[i] <= '0;
            end else if (cnt_clr) begin
                cnt_q[i] <= '0;
            end else if (events[i]) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // read stage 1
    // ----------------------------------------------------------------------
    // the bank has no write path and looks only at the offset
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (bus.offs < NUM_CNT) begin
            rdata <= cnt_q[bus.offs[CNT_IDX_W-1:0]];
        end else begin
            rdata <= '0;
        end
    end

    // whichever counter is read, it has seen at most one increment since the clear
    a_clr_zero : assert property (
        @(posedge clk_sys) disable iff (rst)
        $past(cnt_clr, 3) |-> (rdata <= reg_word_t'(1))
    );

endmodule

`default_nettype wire

// ==== verilog/mmu_rx_err_bank.sv ====
// sticky error registers, set by hardware flags and cleared by writing one over the bus
`timescale 1ns/100ps
`default_nettype none

module mmu_rx_err_bank
    import mmu_rx_reg_pkg::*;
(
    input  wire                      clk_sys,
    input  wire                      rst,
    reg_bus_if.slave                 bus,
    input  wire reg_word_t           rxbd_err,
    input  wire reg_word_t           rxpkt_err,
    input  wire logic [TMOUT_W-1:0]  axi_tmout_err,
    output reg_word_t                rdata
);

    localparam int ERR_IDX_W = $clog2(NUM_ERR);

    reg_word_t err_flag [NUM_ERR];
    reg_word_t err_q    [NUM_ERR];

    // flags in offset order with the timeout flags zero-extended
    assign err_flag[0] = rxbd_err;
    assign err_flag[1] = rxpkt_err;
    assign err_flag[2] = reg_word_t'(axi_tmout_err);

    // ----------------------------------------------------------------------
    // sticky bits
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < NUM_ERR; i++) begin : g_err
        reg_word_t clr_mask;

        assign clr_mask = (bus.wr && (bus.bank == BANK_ERR) && (bus.offs == reg_offs_t'(i))) ?
                          bus.wdata : '0;

        // set wins over a clear in the same cycle
        always_ff @(posedge clk_sys or posedge rst) begin
            if (rst) begin
                err_q[i] <= '0;
            end else begin
                err_q[i] <= (err_q[i] & ~clr_mask) | err_flag[i];
            end
        end

        // a flag shows up in the read word once its register is addressed
        a_flag_sets : assert property (
            @(posedge clk_sys) disable iff (rst)
            (($past(err_flag[i]) != '0) && (bus.offs == reg_offs_t'(i)))
                |=> ((rdata & $past(err_flag[i], 2)) == $past(err_flag[i], 2))
        );
    end

    // ----------------------------------------------------------------------
    // read stage 1
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (bus.offs < NUM_ERR) begin
            rdata <= err_q[bus.offs[ERR_IDX_W-1:0]];
        end else begin
            rdata <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mmu_rx_cfg_bank.sv ====
// read-write configuration registers of the receive MMU, written over the register bus
`timescale 1ns/100ps
`default_nettype none

module mmu_rx_cfg_bank
    import mmu_rx_reg_pkg::*;
(
    input  wire                clk_sys,
    input  wire                rst,
    reg_bus_if.slave           bus,
    output reg_word_t          rdata,
    output logic [TIMER_W-1:0] timer_1us_cfg,
    output logic [TMOUT_W-1:0] tmout_us_cfg,
    output reg_word_t          mmu_rx_cfg
);

    localparam reg_offs_t OFFS_TIMER = 7'd0;
    localparam reg_offs_t OFFS_TMOUT = 7'd1;
    localparam reg_offs_t OFFS_RXCFG = 7'd2;

    logic cfg_wr;

    assign cfg_wr = bus.wr && (bus.bank == BANK_CFG);

    // ----------------------------------------------------------------------
    // registers
    // ----------------------------------------------------------------------
    // each register keeps only its own width of the write data
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            timer_1us_cfg <= TIMER_1US_RST;
            tmout_us_cfg  <= TMOUT_US_RST;
            mmu_rx_cfg    <= RX_CFG_RST;
        end else if (cfg_wr) begin
            case (bus.offs)
                OFFS_TIMER: timer_1us_cfg <= bus.wdata[TIMER_W-1:0];
                OFFS_TMOUT: tmout_us_cfg  <= bus.wdata[TMOUT_W-1:0];
                OFFS_RXCFG: mmu_rx_cfg    <= bus.wdata;
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // read stage 1
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            case (bus.offs)
                OFFS_TIMER: rdata <= reg_word_t'(timer_1us_cfg);
                OFFS_TMOUT: rdata <= reg_word_t'(tmout_us_cfg);
                OFFS_RXCFG: rdata <= mmu_rx_cfg;
                default:    rdata <= '0;
            endcase
        end
    end

    a_cfg_known : assert property (
        @(posedge clk_sys) disable iff (rst)
        !$isunknown({timer_1us_cfg, tmout_us_cfg, mmu_rx_cfg})
    );

endmodule

`default_nettype wire

// ==== verilog/mmu_rx_cpu_port.sv ====
// CPU side of the register block: address decode, bus drive, status select and read mux
`timescale 1ns/100ps
`default_nettype none

module mmu_rx_cpu_port
    import mmu_rx_reg_pkg::*;
#(
    parameter logic [ID_W-1:0] BLOCK_ID = 12'h001
) (
    input  wire            clk_sys,
    input  wire            rst,
    input  wire reg_addr_t cpu_addr,
    input  wire reg_word_t cpu_data_in,
    input  wire            cpu_wr,
    reg_bus_if.master      bus,
    input  wire reg_word_t cfg_rdata,
    input  wire reg_word_t err_rdata,
    input  wire reg_word_t cnt_rdata,
    input  wire reg_word_t sts_words [NUM_STS],
    output reg_word_t      cpu_data_out
);

    localparam int STS_IDX_W = $clog2(NUM_STS);

    logic      hit;
    reg_bank_e bank;
    reg_offs_t offs;
    reg_word_t sts_rdata;
    reg_bank_e bank_q;
    logic      hit_q;

    // ----------------------------------------------------------------------
    // decode
    // ----------------------------------------------------------------------
    // id field must match and the reserved bits must be clear
    assign hit  = (cpu_addr[ADDR_W-1:ID_LSB] == BLOCK_ID) &&
                  (cpu_addr[ZERO_MSB:ZERO_LSB] == '0);
    assign bank = reg_bank_e'(cpu_addr[ZERO_LSB-1:BANK_LSB]);
    assign offs = cpu_addr[OFFS_W-1:0];

    assign bus.offs  = offs;
    assign bus.bank  = bank;
    assign bus.wdata = cpu_data_in;
    assign bus.wr    = cpu_wr & hit;

    // ----------------------------------------------------------------------
    // read stage 1, status words
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            sts_rdata <= '0;
        end else if (offs < NUM_STS) begin
            sts_rdata <= sts_words[offs[STS_IDX_W-1:0]];
        end else begin
            sts_rdata <= '0;
        end
    end

    // ----------------------------------------------------------------------
    // read stage 2, bank mux
    // ----------------------------------------------------------------------
    // bank and hit are registered alongside the stage-1 words
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            bank_q       <= BANK_CFG;
            hit_q        <= 1'b0;
            cpu_data_out <= '0;
        end else begin
            bank_q <= bank;
            hit_q  <= hit;
            if (!hit_q) begin
                cpu_data_out <= '0;
            end else begin
                case (bank_q)
                    BANK_CFG: cpu_data_out <= cfg_rdata;
                    BANK_ERR: cpu_data_out <= err_rdata;
                    BANK_STS: cpu_data_out <= sts_rdata;
                    BANK_CNT: cpu_data_out <= cnt_rdata;
                    default:  cpu_data_out <= '0;
                endcase
            end
        end
    end

    // a write needs a fully known address
    a_wr_addr_known : assert property (
        @(posedge clk_sys) disable iff (rst)
        cpu_wr |-> !$isunknown(cpu_addr)
    );

endmodule

`default_nettype wire

// ==== verilog/reg_bus_if.sv ====
// decoded CPU write path from the CPU port to the register banks
`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if
    import mmu_rx_reg_pkg::*;
();

    reg_offs_t offs;
    reg_word_t wdata;
    reg_bank_e bank;
    // single-cycle strobe, high only on a block hit
    logic      wr;

    modport master (
        output offs,
        output wdata,
        output bank,
        output wr
    );

    // banks only watch the decoded access
    modport slave (
        input offs,
        input wdata,
        input bank,
        input wr
    );

endinterface

`default_nettype wire

// ==== verilog/mmu_rx_reg_pkg.sv ====
// widths, address map, enums and reset values shared by the receive MMU register block
`default_nettype none

package mmu_rx_reg_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int ADDR_W  = 24;
    localparam int DATA_W  = 32;
    localparam int OFFS_W  = 7;
    localparam int ID_W    = 12;
    localparam int BANK_W  = 2;
    localparam int TIMER_W = 8;
    localparam int TMOUT_W = 16;

    // address fields: id 23:12, zero 11:9, bank 8:7, offset 6:0
    localparam int ID_LSB   = ADDR_W - ID_W;
    localparam int ZERO_MSB = ID_LSB - 1;
    localparam int BANK_LSB = OFFS_W;
    localparam int ZERO_LSB = BANK_LSB + BANK_W;

    // register counts per bank
    localparam int NUM_CNT = 7;
    localparam int NUM_ERR = 3;
    localparam int NUM_STS = 4;

    // ----------------------------------------------------------------------
    // types
    // ----------------------------------------------------------------------
    typedef logic [DATA_W-1:0] reg_word_t;
    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [OFFS_W-1:0] reg_offs_t;

    typedef enum logic [BANK_W-1:0] {
        BANK_CFG = 2'd0,
        BANK_ERR = 2'd1,
        BANK_STS = 2'd2,
        BANK_CNT = 2'd3
    } reg_bank_e;

    // counter offsets inside the counter bank
    typedef enum logic [2:0] {
        EV_RXBD   = 3'd0,
        EV_RDCMD  = 3'd1,
        EV_RXPKT0 = 3'd2,
        EV_RXPKT1 = 3'd3,
        EV_RXPKT2 = 3'd4,
        EV_RXPKT3 = 3'd5,
        EV_TXPKT  = 3'd6
    } cnt_event_e;

    // config reset values
    localparam logic [TIMER_W-1:0] TIMER_1US_RST = 8'd200;
    localparam logic [TMOUT_W-1:0] TMOUT_US_RST  = 16'hFFFF;
    localparam reg_word_t          RX_CFG_RST    = 32'h8000_0012;

endpackage

`default_nettype wire
